/* Makefile */
SIM := obj_dir/Vtb_pool_engine

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST RESULT: PASS'

$(SIM): pool_engine.f $(wildcard logic/*.sv test/*.sv)
	verilator --binary --timing --assert -f pool_engine.f --top-module tb_pool_engine \
		-Mdir obj_dir -o Vtb_pool_engine

clean:
	rm -rf obj_dir

/* logic/atom_fifo.sv */
`timescale 1ns/1ps

module atom_fifo (
	input logic clk,
	input logic rst,
	atom_if.buffer aif
);
	logic [pool_pkg::ATOM_W-1:0] mem [pool_pkg::FIFO_DEPTH];
	logic [pool_pkg::PTR_W-1:0] wr_ptr;  // Next free slot
	logic [pool_pkg::PTR_W-1:0] rd_ptr;  // Oldest atom
	logic [pool_pkg::PTR_W:0] count;  // Occupancy, 0 to FIFO_DEPTH

	assign aif.full = (count == pool_pkg::FIFO_DEPTH);
	assign aif.empty = (count == '0);
	assign aif.pop_atom = mem[rd_ptr];  // Show-ahead read

	always_ff @(posedge clk) begin
		if (aif.push) begin
			mem[wr_ptr] <= aif.push_atom;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (aif.push) begin
				wr_ptr <= wr_ptr + 1;
			end
			if (aif.pop) begin
				rd_ptr <= rd_ptr + 1;
			end
			case ({aif.push, aif.pop})
				2'b10: count <= count + 1;
				2'b01: count <= count - 1;
				default: count <= count;  // Both or neither, level unchanged
			endcase
		end
	end
endmodule

/* logic/atom_if.sv */
`timescale 1ns/1ps

// Atom path from reader through the FIFO into the pooling unit
interface atom_if;
	logic push;  // Reader hands over one complete atom
	logic [pool_pkg::ATOM_W-1:0] push_atom;
	logic full;  // No push while set
	logic pop;  // Pooling unit takes the oldest atom
	logic [pool_pkg::ATOM_W-1:0] pop_atom;  // Oldest atom, valid while empty is low
	logic empty;  // No pop while set

	modport producer (
		output push,
		output push_atom,
		input  full
	);

	modport buffer (
		input  push,
		input  push_atom,
		input  pop,
		output full,
		output empty,
		output pop_atom
	);

	modport consumer (output pop, input pop_atom, input empty);
endinterface

/* logic/atom_reader.sv */
`timescale 1ns/1ps

module atom_reader (
	input  logic clk,
	input  logic rst,
	input  logic i_start,
	input  logic [pool_pkg::KLOG_W-1:0] i_kernel_log2,
	input  logic [pool_pkg::WIN_W-1:0] i_windows,
	input  logic [pool_pkg::ADDR_W-1:0] i_data_start_addr,
	input  logic i_rd_we,  // One word strobe from the DMA
	input  logic [pool_pkg::WORD_W-1:0] i_rd_data,
	output logic o_rd_en,  // Level, asks for one burst
	output logic [pool_pkg::ADDR_W-1:0] o_rd_addr,
	atom_if.producer aif
);
	logic [pool_pkg::ATOM_CNT_W-1:0] atoms_left;  // Atoms not yet fully read
	logic [pool_pkg::LANE_W-1:0] word_cnt;  // Word position in the current burst
	logic [pool_pkg::ATOM_W-1:0] atom_reg;  // Deserialized atom
	logic pending;  // Complete atom not yet taken by the FIFO
	logic last_word;

	assign last_word = i_rd_we && (word_cnt == pool_pkg::LAST_LANE);

	// A held atom leaves as soon as the FIFO has room
	assign aif.push = pending && !aif.full;
	assign aif.push_atom = atom_reg;

	// Newest word enters at the top, so word 0 of a burst ends in lane 0
	always_ff @(posedge clk) begin
		if (i_rd_we) begin
			atom_reg <= {i_rd_data, atom_reg[pool_pkg::ATOM_W-1:pool_pkg::WORD_W]};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			atoms_left <= '0;
			word_cnt <= '0;
			pending <= 1'b0;
			o_rd_en <= 1'b0;
			o_rd_addr <= '0;
		end else if (i_start) begin
			// Whole run is windows times 2**klog atoms
			atoms_left <= {{pool_pkg::KCNT_W{1'b0}}, i_windows} << i_kernel_log2;
			word_cnt <= '0;
			pending <= 1'b0;
			o_rd_en <= (i_windows != '0);  // Empty run never asks
			o_rd_addr <= i_data_start_addr;
		end else begin
			if (i_rd_we) begin
				o_rd_addr <= o_rd_addr + 1;  // Next word of the stream
				word_cnt <= word_cnt + 1;
			end
			if (last_word) begin
				// Burst done, hold the atom and stop asking
				word_cnt <= '0;
				pending <= 1'b1;
				o_rd_en <= 1'b0;
				atoms_left <= atoms_left - 1;
			end else if (aif.push) begin
				pending <= 1'b0;
				o_rd_en <= (atoms_left != '0);  // Next burst only if atoms remain
			end
		end
	end
endmodule

/* logic/pool_engine.sv */
`timescale 1ns/1ps

module pool_engine (
	input  logic clk,
	input  logic rst,
	// Run configuration, latched on i_start
	input  logic i_start,
	input  logic [pool_pkg::OP_W-1:0] i_op_type,
	input  logic [pool_pkg::KLOG_W-1:0] i_kernel_log2,
	input  logic [pool_pkg::WIN_W-1:0] i_windows,
	input  logic [pool_pkg::ADDR_W-1:0] i_data_start_addr,
	input  logic [pool_pkg::ADDR_W-1:0] i_result_start_addr,
	// DMA read port
	input  logic i_rd_we,
	input  logic [pool_pkg::WORD_W-1:0] i_rd_data,
	output logic o_rd_en,
	output logic [pool_pkg::ADDR_W-1:0] o_rd_addr,
	// DMA write port
	input  logic i_wr_re,
	output logic o_wr_req,
	output logic [pool_pkg::ADDR_W-1:0] o_wr_addr,
	output logic [pool_pkg::WORD_W-1:0] o_wr_data,
	output logic o_wr_valid,
	output logic o_done
);
	atom_if aif ();  // Reader to FIFO to pooling unit

	atom_reader u_reader (
		.clk               (clk),
		.rst               (rst),
		.i_start           (i_start),
		.i_kernel_log2     (i_kernel_log2),
		.i_windows         (i_windows),
		.i_data_start_addr (i_data_start_addr),
		.i_rd_we           (i_rd_we),
		.i_rd_data         (i_rd_data),
		.o_rd_en           (o_rd_en),
		.o_rd_addr         (o_rd_addr),
		.aif               (aif.producer)
	);

	atom_fifo u_fifo (
		.clk (clk),
		.rst (rst),
		.aif (aif.buffer)
	);

	pool_unit u_pool (
		.clk                 (clk),
		.rst                 (rst),
		.i_start             (i_start),
		.i_op_type           (i_op_type),
		.i_kernel_log2       (i_kernel_log2),
		.i_windows           (i_windows),
		.i_result_start_addr (i_result_start_addr),
		.i_wr_re             (i_wr_re),
		.o_wr_req            (o_wr_req),
		.o_wr_addr           (o_wr_addr),
		.o_wr_data           (o_wr_data),
		.o_wr_valid          (o_wr_valid),
		.o_done              (o_done),
		.aif                 (aif.consumer)
	);
endmodule

/* logic/pool_pkg.sv */
package pool_pkg;
	// Datapath widths
	localparam int WORD_W = 16;  // One lane and one DMA word
	localparam int BURST_LEN = 4;  // Lanes per atom, words per read burst
	localparam int ATOM_W = WORD_W * BURST_LEN;
	localparam int ADDR_W = 30;  // DMA word address
	localparam int LANE_W = $clog2(BURST_LEN);
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(BURST_LEN - 1);

	// Atom buffer between reader and pooling unit
	localparam int FIFO_DEPTH = 4;
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// Run configuration
	localparam int OP_W = 3;
	localparam logic [OP_W-1:0] OP_MAXPOOL = 3'd4;
	localparam logic [OP_W-1:0] OP_AVEPOOL = 3'd5;
	localparam int KLOG_W = 2;  // log2 of atoms per window
	localparam int KCNT_W = 2 ** KLOG_W - 1;  // Atom index in a window, 1 to 8 atoms
	localparam int WIN_W = 8;  // Window count of one run
	localparam int ATOM_CNT_W = WIN_W + KCNT_W;  // Atoms of a whole run
	localparam int SUM_W = WORD_W + KCNT_W;  // Eight lanes add up without overflow

	// Pooling unit FSM encoding
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
	localparam logic [ST_W-1:0] ST_POOL = 2'd1;  // Popping atoms of a window
	localparam logic [ST_W-1:0] ST_WRITE = 2'd2;  // Lane results out one by one
endpackage

/* logic/pool_unit.sv */
`timescale 1ns/1ps

module pool_unit (
	input  logic clk,
	input  logic rst,
	input  logic i_start,
	input  logic [pool_pkg::OP_W-1:0] i_op_type,
	input  logic [pool_pkg::KLOG_W-1:0] i_kernel_log2,
	input  logic [pool_pkg::WIN_W-1:0] i_windows,
	input  logic [pool_pkg::ADDR_W-1:0] i_result_start_addr,
	input  logic i_wr_re,  // DMA takes the word next cycle
	output logic o_wr_req,
	output logic [pool_pkg::ADDR_W-1:0] o_wr_addr,
	output logic [pool_pkg::WORD_W-1:0] o_wr_data,
	output logic o_wr_valid,
	output logic o_done,
	atom_if.consumer aif
);
	logic [pool_pkg::ST_W-1:0] state;
	logic [pool_pkg::OP_W-1:0] op_q;
	logic [pool_pkg::KLOG_W-1:0] klog_q;
	logic [pool_pkg::WIN_W-1:0] win_left;  // Windows still to write
	logic [pool_pkg::KCNT_W-1:0] atom_idx;  // Atom position in the window
	logic [pool_pkg::KCNT_W-1:0] last_idx;
	logic [pool_pkg::LANE_W-1:0] lane;  // Lane being written
	logic [pool_pkg::SUM_W-1:0] acc [pool_pkg::BURST_LEN];
	logic [pool_pkg::SUM_W-1:0] lane_in [pool_pkg::BURST_LEN];
	logic [pool_pkg::SUM_W-1:0] lane_avg;
	logic [pool_pkg::WORD_W-1:0] lane_word;

	// 2**klog - 1 without a multiplier
	assign last_idx = ~({pool_pkg::KCNT_W{1'b1}} << klog_q);
	assign aif.pop = (state == pool_pkg::ST_POOL) && !aif.empty;

	always_comb begin
		for (int i = 0; i < pool_pkg::BURST_LEN; i++) begin
			lane_in[i] = {{pool_pkg::KCNT_W{1'b0}}, aif.pop_atom[i*pool_pkg::WORD_W +: pool_pkg::WORD_W]};
		end
	end

	// Window size is a power of two, the average is a shift
	assign lane_avg = acc[lane] >> klog_q;
	assign lane_word = (op_q == pool_pkg::OP_AVEPOOL) ? lane_avg[pool_pkg::WORD_W-1:0]
		: acc[lane][pool_pkg::WORD_W-1:0];

	// Lane accumulators, first atom of a window loads them
	always_ff @(posedge clk) begin
		if (aif.pop) begin
			for (int i = 0; i < pool_pkg::BURST_LEN; i++) begin
				if (atom_idx == '0) begin
					acc[i] <= lane_in[i];
				end else begin
					case (op_q)
						pool_pkg::OP_AVEPOOL: acc[i] <= acc[i] + lane_in[i];
						pool_pkg::OP_MAXPOOL: acc[i] <= (lane_in[i] > acc[i]) ? lane_in[i] : acc[i];
						default: acc[i] <= acc[i];  // Unknown op keeps the first atom
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (o_wr_req && i_wr_re) begin
			o_wr_data <= lane_word;  // Shown with o_wr_valid
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= pool_pkg::ST_IDLE;
			op_q <= '0;
			klog_q <= '0;
			win_left <= '0;
			atom_idx <= '0;
			lane <= '0;
			o_wr_req <= 1'b0;
			o_wr_valid <= 1'b0;
			o_wr_addr <= '0;
			o_done <= 1'b0;
		end else if (i_start) begin
			op_q <= i_op_type;
			klog_q <= i_kernel_log2;
			win_left <= i_windows;
			atom_idx <= '0;
			lane <= '0;
			o_wr_req <= 1'b0;
			o_wr_valid <= 1'b0;
			o_wr_addr <= i_result_start_addr;
			o_done <= (i_windows == '0);  // Nothing to pool
			state <= (i_windows == '0) ? pool_pkg::ST_IDLE : pool_pkg::ST_POOL;
		end else begin
			case (state)
				pool_pkg::ST_POOL: begin
					if (aif.pop) begin
						if (atom_idx == last_idx) begin
							// Window complete, request for lane 0 next cycle
							atom_idx <= '0;
							lane <= '0;
							o_wr_req <= 1'b1;
							state <= pool_pkg::ST_WRITE;
						end else begin
							atom_idx <= atom_idx + 1;
						end
					end
				end
				pool_pkg::ST_WRITE: begin
					if (o_wr_valid) begin
						o_wr_valid <= 1'b0;
						o_wr_addr <= o_wr_addr + 1;
						if (lane != pool_pkg::LAST_LANE) begin
							lane <= lane + 1;
							o_wr_req <= 1'b1;  // Next lane of the same window
						end else begin
							lane <= '0;
							win_left <= win_left - 1;
							if (win_left == 1) begin
								o_done <= 1'b1;  // Holds until the next start
								state <= pool_pkg::ST_IDLE;
							end else begin
								state <= pool_pkg::ST_POOL;
							end
						end
					end else if (o_wr_req && i_wr_re) begin
						o_wr_req <= 1'b0;
						o_wr_valid <= 1'b1;
					end
				end
				default: state <= pool_pkg::ST_IDLE;  // Waits for i_start
			endcase
		end
	end
endmodule

/* pool_engine.f */
logic/pool_pkg.sv
logic/atom_if.sv
logic/atom_reader.sv
logic/atom_fifo.sv
logic/pool_unit.sv
logic/pool_engine.sv
test/tb_clock.sv
test/pool_engine_sva.sv
test/tb_pool_engine.sv

/* test/pool_engine_sva.sv */
`timescale 1ns/1ps

// Write and read port protocol of the engine
module pool_engine_sva (
	input logic clk,
	input logic rst,
	input logic i_rd_en,  // DUT o_rd_en
	input logic i_wr_req,  // DUT o_wr_req
	input logic i_wr_re,
	input logic i_wr_valid  // DUT o_wr_valid
);
	// Valid exactly one cycle after the DMA read enable
	wr_valid_after_re: assert property (@(posedge clk) disable iff (rst) i_wr_re |=> i_wr_valid)
		else $error("o_wr_valid missing one cycle after i_wr_re");
	wr_valid_only_after_re: assert property (
		@(posedge clk) disable iff (rst) i_wr_valid |-> $past(i_wr_re))
		else $error("o_wr_valid without i_wr_re in the cycle before");

	// Request held until the DMA answers
	wr_req_held: assert property (@(posedge clk) disable iff (rst) i_wr_req && !i_wr_re |=> i_wr_req)
		else $error("o_wr_req dropped before i_wr_re");

	rd_en_low_after_reset: assert property (@(posedge clk) rst |=> !i_rd_en)
		else $error("o_rd_en high in the cycle after reset");
endmodule

bind pool_engine pool_engine_sva u_sva (
	.clk        (clk),
	.rst        (rst),
	.i_rd_en    (o_rd_en),
	.i_wr_req   (o_wr_req),
	.i_wr_re    (i_wr_re),
	.i_wr_valid (o_wr_valid)
);

/* test/tb_clock.sv */
`timescale 1ns/1ps

// Free-running 4 ns clock, reset over the first two cycles
module tb_clock (
	output logic o_clk,
	output logic o_rst
);
	initial begin
		o_clk = 1'b0;
		o_rst = 1'b1;
		#8 o_rst = 1'b0;  // Two periods, released on a falling edge
	end

	always #2 o_clk = ~o_clk;  // Half period
endmodule

/* test/tb_pool_engine.sv */
`timescale 1ns/1ps

module tb_pool_engine;
	logic clk;
	logic rst;
	logic i_start;
	logic [pool_pkg::OP_W-1:0] i_op_type;
	logic [pool_pkg::KLOG_W-1:0] i_kernel_log2;
	logic [pool_pkg::WIN_W-1:0] i_windows;
	logic [pool_pkg::ADDR_W-1:0] i_data_start_addr;
	logic [pool_pkg::ADDR_W-1:0] i_result_start_addr;
	logic i_rd_we;
	logic [pool_pkg::WORD_W-1:0] i_rd_data;
	logic o_rd_en;
	logic [pool_pkg::ADDR_W-1:0] o_rd_addr;
	logic i_wr_re;
	logic o_wr_req;
	logic [pool_pkg::ADDR_W-1:0] o_wr_addr;
	logic [pool_pkg::WORD_W-1:0] o_wr_data;
	logic o_wr_valid;
	logic o_done;

	logic [pool_pkg::WORD_W-1:0] exp_data [$];  // Expected results of all runs, in write order
	logic [pool_pkg::ADDR_W-1:0] exp_addr [$];
	int wr_seen = 0;  // Writes observed so far
	logic [pool_pkg::ADDR_W-1:0] rd_base = '0;  // Data start of the current run
	int rd_count = 0;  // Words delivered over all runs
	int rd_mark = 0;  // rd_count when the current run started
	int rd_words = 0;  // Words the current run must read
	int wr_delay_max = 2;  // Upper bound of the i_wr_re delay
	int stall_run = 0;
	int stall_max = 0;  // Longest reader stall with reads left
	int data_errs = 0;
	int addr_errs = 0;
	int rd_errs = 0;
	int seq_errs = 0;
	int misc_errs = 0;

	tb_clock u_clock (.o_clk(clk), .o_rst(rst));

	pool_engine DUT (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Memory content, a hash of the full word address
	function automatic logic [pool_pkg::WORD_W-1:0] word_at(input logic [pool_pkg::ADDR_W-1:0] a);
		logic [31:0] h;
		h = xorshift32({2'b00, a} ^ 32'h5bd1e995);
		h = xorshift32(h);
		return h[pool_pkg::WORD_W-1:0];
	endfunction

	// Per-lane max, or sum then shift, over consecutive atoms
	task automatic build_expected(input logic [pool_pkg::OP_W-1:0] op,
		input logic [pool_pkg::KLOG_W-1:0] klog, input logic [pool_pkg::WIN_W-1:0] wins,
		input logic [pool_pkg::ADDR_W-1:0] dbase, input logic [pool_pkg::ADDR_W-1:0] rbase);
		int k;
		logic [31:0] acc;
		logic [31:0] w;
		k = 1 << klog;
		for (int win = 0; win < int'(wins); win++) begin
			for (int l = 0; l < pool_pkg::BURST_LEN; l++) begin
				acc = '0;  // Unsigned lanes, zero is neutral for max too
				for (int a = 0; a < k; a++) begin
					w = 32'(word_at(dbase + 30'((win * k + a) * pool_pkg::BURST_LEN + l)));
					if (op == pool_pkg::OP_MAXPOOL) begin
						acc = (w > acc) ? w : acc;
					end else begin
						acc = acc + w;
					end
				end
				if (op == pool_pkg::OP_AVEPOOL) begin
					acc = acc >> klog;
				end
				exp_data.push_back(acc[pool_pkg::WORD_W-1:0]);
				exp_addr.push_back(rbase + 30'(win * pool_pkg::BURST_LEN + l));
			end
		end
	endtask

	task automatic run_pool(input logic [pool_pkg::OP_W-1:0] op,
		input logic [pool_pkg::KLOG_W-1:0] klog, input logic [pool_pkg::WIN_W-1:0] wins,
		input int delay_max, input logic [pool_pkg::ADDR_W-1:0] dbase,
		input logic [pool_pkg::ADDR_W-1:0] rbase);
		build_expected(op, klog, wins, dbase, rbase);
		wr_delay_max = delay_max;
		rd_base = dbase;
		rd_mark = rd_count;  // Reader idle here, count is settled
		rd_words = int'(wins) * (1 << klog) * pool_pkg::BURST_LEN;
		i_op_type = op;
		i_kernel_log2 = klog;
		i_windows = wins;
		i_data_start_addr = dbase;
		i_result_start_addr = rbase;
		i_start = 1'b1;  // One-cycle pulse
		@(negedge clk);
		i_start = 1'b0;
		while (!o_done) @(negedge clk);
		assert (wr_seen == exp_data.size()) else begin
			misc_errs++;
			$display("Run done with %0d of %0d results written", wr_seen, exp_data.size());
		end
		assert (rd_count - rd_mark == rd_words) else begin
			misc_errs++;
			$display("Run read %0d words instead of %0d", rd_count - rd_mark, rd_words);
		end
		repeat (4) begin
			@(negedge clk);
			assert (o_done) else begin
				misc_errs++;
				$display("o_done dropped without a new start");
			end
		end
	endtask

	// Read DMA, BURST_LEN strobes per request with random gaps
	initial begin : dma_read
		logic [31:0] rnd;
		logic [pool_pkg::ADDR_W-1:0] exp_rd;
		int gap;
		rnd = 32'h372c391c;
		i_rd_we = 1'b0;
		i_rd_data = '0;
		forever begin
			@(negedge clk);
			if (o_rd_en) begin
				repeat (pool_pkg::BURST_LEN) begin
					rnd = xorshift32(rnd);
					gap = int'(rnd % 32'd3);
					repeat (gap) @(negedge clk);
					exp_rd = rd_base + 30'(rd_count - rd_mark);  // Stream is contiguous
					assert (o_rd_addr == exp_rd) else begin
						rd_errs++;
						$display("ERROR o_rd_addr: got %h, expected %h", o_rd_addr, exp_rd);
					end
					i_rd_we = 1'b1;
					i_rd_data = word_at(o_rd_addr);
					rd_count++;
					@(negedge clk);
					i_rd_we = 1'b0;
				end
			end
		end
	end

	// Write DMA, answers each request after a random delay
	initial begin : dma_write
		logic [31:0] rnd;
		int delay;
		rnd = 32'h372c391c;
		i_wr_re = 1'b0;
		forever begin
			@(negedge clk);
			if (o_wr_req) begin
				rnd = xorshift32(rnd);
				delay = int'(rnd % 32'(wr_delay_max + 1));
				repeat (delay) @(negedge clk);
				i_wr_re = 1'b1;
				@(negedge clk);
				i_wr_re = 1'b0;
			end
		end
	end

	always @(negedge clk) begin : write_monitor
		if (o_wr_valid) begin
			assert (!o_done) else begin
				seq_errs++;
				$display("o_done high during a result write");
			end
			assert (wr_seen < exp_data.size()) else begin
				seq_errs++;
				$display("Write to %h with no result expected", o_wr_addr);
			end
			if (wr_seen < exp_data.size()) begin
				assert (o_wr_data == exp_data[wr_seen]) else begin
					data_errs++;
					$display("ERROR o_wr_data: got %h, expected %h", o_wr_data, exp_data[wr_seen]);
				end
				assert (o_wr_addr == exp_addr[wr_seen]) else begin
					addr_errs++;
					$display("ERROR o_wr_addr: got %h, expected %h", o_wr_addr, exp_addr[wr_seen]);
				end
			end
			wr_seen++;
		end
		// Reader quiet while words of the run are still unread
		if (!o_rd_en && !o_done && (rd_count - rd_mark) != rd_words) begin
			stall_run++;
		end else begin
			stall_run = 0;
		end
		stall_max = (stall_run > stall_max) ? stall_run : stall_max;
	end

	initial begin : watchdog
		int run_words;
		run_words = 3*4*4 + 5*2*4 + 2*8*4 + 4*1*4 + 6*2*4;  // Windows x atoms x lanes, all runs
		#(run_words * 64 * 4);  // 64 cycles of 4 ns per word
		$display("Timeout, runs not finished after %0d ns", run_words * 64 * 4);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : main
		i_start = 1'b0;
		i_op_type = '0;
		i_kernel_log2 = '0;
		i_windows = '0;
		i_data_start_addr = '0;
		i_result_start_addr = '0;
		@(negedge rst);
		repeat (6) begin
			@(negedge clk);
			assert (!o_rd_en && !o_wr_req && !o_wr_valid && !o_done) else begin
				misc_errs++;
				$display("Engine active after reset without a start");
			end
		end
		run_pool(pool_pkg::OP_MAXPOOL, 2'd2, 8'd3, 2, 30'h100, 30'h4000);  // 4 atoms per window
		run_pool(pool_pkg::OP_AVEPOOL, 2'd1, 8'd5, 2, 30'h2000, 30'h4100);
		run_pool(pool_pkg::OP_AVEPOOL, 2'd3, 8'd2, 2, 30'h3ff0, 30'h4200);  // 8 atoms
		run_pool(pool_pkg::OP_MAXPOOL, 2'd0, 8'd4, 2, 30'h1234567, 30'h4300);  // Pass-through
		run_pool(pool_pkg::OP_AVEPOOL, 2'd1, 8'd6, 40, 30'h500, 30'h4400);  // Slow write side
		assert (stall_max > 8) else begin
			misc_errs++;
			$display("Reader never held off by a full FIFO, longest stall %0d cycles", stall_max);
		end
		$display("Errors: data %0d, address %0d, read %0d, sequence %0d, other %0d",
			data_errs, addr_errs, rd_errs, seq_errs, misc_errs);
		if (data_errs + addr_errs + rd_errs + seq_errs + misc_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end
endmodule
